// ==== opreq_pkg.sv ====
/*
 * Shared sizes and types for the lane operand requester.
 * Modules take the types by scoped name in their port lists and
 * import the package inside the body where they need more.
 */
package opreq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Instruction IDs in flight
  localparam int unsigned NrVInsn = 8;
  // One read requester per operand queue
  localparam int unsigned NrOpQueues = 2;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;
  // 64-bit words of one register held in this lane
  localparam int unsigned WordsPerVReg = 16;

  localparam int unsigned IdW = $clog2(NrVInsn);
  localparam int unsigned VRegW = $clog2(NrVRegs);
  localparam int unsigned VAddrW = $clog2(NrVRegs * WordsPerVReg);
  // One extra bit so a full register length fits
  localparam int unsigned WLenW = $clog2(WordsPerVReg + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [IdW-1:0] vid_t;
  typedef logic [VRegW-1:0] vreg_t;
  // Word address inside the lane, bank in the low bits
  typedef logic [VAddrW-1:0] vaddr_t;
  typedef logic [WLenW-1:0] wlen_t;

  typedef logic [63:0] elen_t;
  typedef logic [$bits(elen_t)/8-1:0] strb_t;

endpackage

// ==== result_spill_reg.sv ====
/*
 * Two-entry in-order buffer on the load unit result path.
 * The load unit sees a grant while a slot is free; the buffered word
 * goes on to the bank arbiter, and final_gnt_o marks the cycle after it
 * was actually written into the VRF.
 */
`timescale 1ns/1ns

module result_spill_reg (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                in_req_i,
  input  opreq_pkg::vid_t     in_id_i,
  input  opreq_pkg::vaddr_t   in_addr_i,
  input  opreq_pkg::elen_t    in_wdata_i,
  input  opreq_pkg::strb_t    in_be_i,
  output logic                in_gnt_o,
  output logic                out_req_o,
  output opreq_pkg::vid_t     out_id_o,
  output opreq_pkg::vaddr_t   out_addr_o,
  output opreq_pkg::elen_t    out_wdata_o,
  output opreq_pkg::strb_t    out_be_o,
  input  logic                out_gnt_i,
  output logic                final_gnt_o
);
  import opreq_pkg::*;

  // Storage slots, addressed as a tiny circular buffer
  vid_t       id_q    [2];
  vaddr_t     addr_q  [2];
  elen_t      wdata_q [2];
  strb_t      be_q    [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign in_gnt_o  = (count_q != 2'd2);
  assign push      = in_req_i && in_gnt_o;
  assign out_req_o = (count_q != 2'd0);
  assign pop       = out_req_o && out_gnt_i;

  // Oldest entry is always presented first
  assign out_id_o    = id_q[rd_ptr_q];
  assign out_addr_o  = addr_q[rd_ptr_q];
  assign out_wdata_o = wdata_q[rd_ptr_q];
  assign out_be_o    = be_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_ptr_q]    <= in_id_i;
      addr_q[wr_ptr_q]  <= in_addr_i;
      wdata_q[wr_ptr_q] <= in_wdata_i;
      be_q[wr_ptr_q]    <= in_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      final_gnt_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
      // Release the dependent instruction only once the word is in the VRF
      final_gnt_o <= out_gnt_i;
    end
  end

endmodule

// ==== operand_req_fsm.sv ====
/*
 * Read requester for one operand queue.
 * Takes a command (ID, source register, word count, hazard mask) and
 * walks the register's words in address order, one request per cycle,
 * paced by the writes of the instructions it depends on.
 */
`timescale 1ns/1ns

module operand_req_fsm #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned BankW   = $clog2(NrBanks),
  localparam int unsigned RowW    = opreq_pkg::VAddrW - BankW
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Command from the lane sequencer
  input  logic                          cmd_valid_i,
  input  opreq_pkg::vid_t               cmd_id_i,
  input  opreq_pkg::vreg_t              cmd_vs_i,
  input  opreq_pkg::wlen_t              cmd_len_i,
  input  logic [opreq_pkg::NrVInsn-1:0] cmd_hazard_i,
  output logic                          cmd_ready_o,
  // Operand queue and hazard tracking
  input  logic                          queue_ready_i,
  input  logic [opreq_pkg::NrVInsn-1:0] vinsn_written_i,
  // Request towards the bank arbiter
  output logic                          rd_req_o,
  output logic [BankW-1:0]              rd_bank_o,
  output logic [RowW-1:0]               rd_row_o,
  input  logic                          rd_gnt_i,
  output logic                          issued_o
);
  import opreq_pkg::*;

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e             state_d, state_q;
  vaddr_t             addr_d, addr_q;
  wlen_t              len_d, len_q;
  logic [NrVInsn-1:0] hazard_d, hazard_q;
  logic               stall;
  logic               granted;
  logic               last_word;

  // Wait until every instruction we depend on wrote a word last cycle
  assign stall = |(hazard_q & ~vinsn_written_i);

  assign rd_req_o  = (state_q == REQUESTING) && queue_ready_i && !stall;
  assign rd_bank_o = addr_q[BankW-1:0];
  assign rd_row_o  = addr_q[VAddrW-1:BankW];

  assign granted   = rd_req_o && rd_gnt_i;
  assign issued_o  = granted;
  assign last_word = granted && (len_q == wlen_t'(1));

  // Acknowledge when idle, or back to back on the last word
  assign cmd_ready_o = cmd_valid_i && ((state_q == IDLE) || last_word);

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    len_d    = len_q;
    hazard_d = hazard_q;

    if (granted) begin
      addr_d = addr_q + 1'b1;
      len_d  = len_q - 1'b1;
      if (last_word) begin
        state_d = IDLE;
      end
    end

    if (cmd_ready_o) begin
      addr_d   = vaddr_t'(cmd_vs_i) * vaddr_t'(WordsPerVReg);
      len_d    = cmd_len_i;
      hazard_d = cmd_hazard_i;
      // An instruction never waits on its own results
      hazard_d[cmd_id_i] = 1'b0;
      // Zero-length commands are acknowledged but issue nothing
      state_d = (cmd_len_i == '0) ? IDLE : REQUESTING;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      len_q    <= '0;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
    end
  end

endmodule

// ==== vrf_bank_arbiter.sv ====
/*
 * Per-bank VRF arbiter. Writes beat reads with fixed priority, the
 * arithmetic unit before the load unit; the readers share a bank by
 * round robin. Also registers which instructions wrote this cycle.
 */
`timescale 1ns/1ns

module vrf_bank_arbiter #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned BankW   = $clog2(NrBanks),
  localparam int unsigned RowW    = opreq_pkg::VAddrW - BankW,
  localparam int unsigned QW      = $clog2(opreq_pkg::NrOpQueues)
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Operand reads
  input  logic [opreq_pkg::NrOpQueues-1:0]             rd_req_i,
  input  logic [opreq_pkg::NrOpQueues-1:0][BankW-1:0]  rd_bank_i,
  input  logic [opreq_pkg::NrOpQueues-1:0][RowW-1:0]   rd_row_i,
  output logic [opreq_pkg::NrOpQueues-1:0]             rd_gnt_o,
  // Arithmetic unit writes
  input  logic                                         alu_req_i,
  input  opreq_pkg::vid_t                              alu_id_i,
  input  opreq_pkg::vaddr_t                            alu_addr_i,
  input  opreq_pkg::elen_t                             alu_wdata_i,
  input  opreq_pkg::strb_t                             alu_be_i,
  output logic                                         alu_gnt_o,
  // Buffered load unit writes
  input  logic                                         ldu_req_i,
  input  opreq_pkg::vid_t                              ldu_id_i,
  input  opreq_pkg::vaddr_t                            ldu_addr_i,
  input  opreq_pkg::elen_t                             ldu_wdata_i,
  input  opreq_pkg::strb_t                             ldu_be_i,
  output logic                                         ldu_gnt_o,
  output logic [opreq_pkg::NrVInsn-1:0]                vinsn_written_o,
  // Bank ports
  output logic [NrBanks-1:0]                           vrf_req_o,
  output logic [NrBanks-1:0][RowW-1:0]                 vrf_addr_o,
  output logic [NrBanks-1:0]                           vrf_wen_o,
  output opreq_pkg::elen_t [NrBanks-1:0]               vrf_wdata_o,
  output opreq_pkg::strb_t [NrBanks-1:0]               vrf_be_o,
  output logic [NrBanks-1:0][QW-1:0]                   vrf_tgt_o
);
  import opreq_pkg::*;

  logic [BankW-1:0]          alu_bank, ldu_bank;
  logic [RowW-1:0]           alu_row, ldu_row;
  logic [NrBanks-1:0][QW-1:0] rr_d, rr_q;
  logic [NrVInsn-1:0]        written_d;

  assign alu_bank = alu_addr_i[BankW-1:0];
  assign alu_row  = alu_addr_i[VAddrW-1:BankW];
  assign ldu_bank = ldu_addr_i[BankW-1:0];
  assign ldu_row  = ldu_addr_i[VAddrW-1:BankW];

  always_comb begin
    logic found;
    int   q;

    alu_gnt_o   = 1'b0;
    ldu_gnt_o   = 1'b0;
    rd_gnt_o    = '0;
    rr_d        = rr_q;
    vrf_req_o   = '0;
    vrf_addr_o  = '0;
    vrf_wen_o   = '0;
    vrf_wdata_o = '0;
    vrf_be_o    = '0;
    vrf_tgt_o   = '0;
    found       = 1'b0;
    q           = 0;

    for (int b = 0; b < NrBanks; b++) begin
      found = 1'b0;
      if (alu_req_i && (alu_bank == BankW'(b))) begin
        // Arithmetic results never wait
        alu_gnt_o      = 1'b1;
        vrf_req_o[b]   = 1'b1;
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = alu_row;
        vrf_wdata_o[b] = alu_wdata_i;
        vrf_be_o[b]    = alu_be_i;
      end else if (ldu_req_i && (ldu_bank == BankW'(b))) begin
        ldu_gnt_o      = 1'b1;
        vrf_req_o[b]   = 1'b1;
        vrf_wen_o[b]   = 1'b1;
        vrf_addr_o[b]  = ldu_row;
        vrf_wdata_o[b] = ldu_wdata_i;
        vrf_be_o[b]    = ldu_be_i;
      end else begin
        // Start the search at this bank's pointer
        for (int k = 0; k < NrOpQueues; k++) begin
          q = (int'(rr_q[b]) + k) % int'(NrOpQueues);
          if (!found && rd_req_i[q] && (rd_bank_i[q] == BankW'(b))) begin
            found         = 1'b1;
            rd_gnt_o[q]   = 1'b1;
            vrf_req_o[b]  = 1'b1;
            vrf_addr_o[b] = rd_row_i[q];
            vrf_tgt_o[b]  = QW'(q);
            rr_d[b]       = QW'((q + 1) % int'(NrOpQueues));
          end
        end
      end
    end

    written_d = '0;
    written_d[alu_id_i] = alu_gnt_o;
    written_d[ldu_id_i] = written_d[ldu_id_i] | ldu_gnt_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q            <= '0;
      vinsn_written_o <= '0;
    end else begin
      rr_q            <= rr_d;
      vinsn_written_o <= written_d;
    end
  end

endmodule

// ==== operand_requester.sv ====
/*
 * Lane operand requester for a banked VRF.
 * Buffers load results, runs one read requester per operand queue and
 * arbitrates every bank between writes and reads each cycle.
 */
`timescale 1ns/1ns

module operand_requester #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned BankW   = $clog2(NrBanks),
  localparam int unsigned RowW    = opreq_pkg::VAddrW - BankW,
  localparam int unsigned NrQ     = opreq_pkg::NrOpQueues
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Commands, one per operand queue
  input  logic [NrQ-1:0]                           operand_request_valid_i,
  input  opreq_pkg::vid_t [NrQ-1:0]                op_id_i,
  input  opreq_pkg::vreg_t [NrQ-1:0]               op_vs_i,
  input  opreq_pkg::wlen_t [NrQ-1:0]               op_len_i,
  input  logic [NrQ-1:0][opreq_pkg::NrVInsn-1:0]   op_hazard_i,
  output logic [NrQ-1:0]                           operand_request_ready_o,
  // Operand queues
  input  logic [NrQ-1:0]                           operand_queue_ready_i,
  output logic [NrQ-1:0]                           operand_issued_o,
  // Arithmetic unit results
  input  logic                                     alu_result_req_i,
  input  opreq_pkg::vid_t                          alu_result_id_i,
  input  opreq_pkg::vaddr_t                        alu_result_addr_i,
  input  opreq_pkg::elen_t                         alu_result_wdata_i,
  input  opreq_pkg::strb_t                         alu_result_be_i,
  output logic                                     alu_result_gnt_o,
  // Load unit results
  input  logic                                     ldu_result_req_i,
  input  opreq_pkg::vid_t                          ldu_result_id_i,
  input  opreq_pkg::vaddr_t                        ldu_result_addr_i,
  input  opreq_pkg::elen_t                         ldu_result_wdata_i,
  input  opreq_pkg::strb_t                         ldu_result_be_i,
  output logic                                     ldu_result_gnt_o,
  output logic                                     ldu_result_final_gnt_o,
  // VRF banks
  output logic [NrBanks-1:0]                       vrf_req_o,
  output logic [NrBanks-1:0][RowW-1:0]             vrf_addr_o,
  output logic [NrBanks-1:0]                       vrf_wen_o,
  output opreq_pkg::elen_t [NrBanks-1:0]           vrf_wdata_o,
  output opreq_pkg::strb_t [NrBanks-1:0]           vrf_be_o,
  output logic [NrBanks-1:0][$clog2(NrQ)-1:0]      vrf_tgt_o
);
  import opreq_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Load result buffering
  ////////////////////////////////////////////////////////////////////////////

  logic   ldu_req;
  vid_t   ldu_id;
  vaddr_t ldu_addr;
  elen_t  ldu_wdata;
  strb_t  ldu_be;
  logic   ldu_wr_gnt;

  result_spill_reg i_ldu_spill (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_req_i   (ldu_result_req_i),
    .in_id_i    (ldu_result_id_i),
    .in_addr_i  (ldu_result_addr_i),
    .in_wdata_i (ldu_result_wdata_i),
    .in_be_i    (ldu_result_be_i),
    .in_gnt_o   (ldu_result_gnt_o),
    .out_req_o  (ldu_req),
    .out_id_o   (ldu_id),
    .out_addr_o (ldu_addr),
    .out_wdata_o(ldu_wdata),
    .out_be_o   (ldu_be),
    .out_gnt_i  (ldu_wr_gnt),
    .final_gnt_o(ldu_result_final_gnt_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operand requesters
  ////////////////////////////////////////////////////////////////////////////

  logic [NrQ-1:0]            rd_req;
  logic [NrQ-1:0][BankW-1:0] rd_bank;
  logic [NrQ-1:0][RowW-1:0]  rd_row;
  logic [NrQ-1:0]            rd_gnt;
  logic [NrVInsn-1:0]        vinsn_written_q;

  for (genvar q = 0; q < NrQ; q++) begin : gen_opreq
    operand_req_fsm #(
      .NrBanks(NrBanks)
    ) i_opreq (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cmd_valid_i    (operand_request_valid_i[q]),
      .cmd_id_i       (op_id_i[q]),
      .cmd_vs_i       (op_vs_i[q]),
      .cmd_len_i      (op_len_i[q]),
      .cmd_hazard_i   (op_hazard_i[q]),
      .cmd_ready_o    (operand_request_ready_o[q]),
      .queue_ready_i  (operand_queue_ready_i[q]),
      .vinsn_written_i(vinsn_written_q),
      .rd_req_o       (rd_req[q]),
      .rd_bank_o      (rd_bank[q]),
      .rd_row_o       (rd_row[q]),
      .rd_gnt_i       (rd_gnt[q]),
      .issued_o       (operand_issued_o[q])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank arbitration
  ////////////////////////////////////////////////////////////////////////////

  vrf_bank_arbiter #(
    .NrBanks(NrBanks)
  ) i_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_req_i       (rd_req),
    .rd_bank_i      (rd_bank),
    .rd_row_i       (rd_row),
    .rd_gnt_o       (rd_gnt),
    .alu_req_i      (alu_result_req_i),
    .alu_id_i       (alu_result_id_i),
    .alu_addr_i     (alu_result_addr_i),
    .alu_wdata_i    (alu_result_wdata_i),
    .alu_be_i       (alu_result_be_i),
    .alu_gnt_o      (alu_result_gnt_o),
    .ldu_req_i      (ldu_req),
    .ldu_id_i       (ldu_id),
    .ldu_addr_i     (ldu_addr),
    .ldu_wdata_i    (ldu_wdata),
    .ldu_be_i       (ldu_be),
    .ldu_gnt_o      (ldu_wr_gnt),
    .vinsn_written_o(vinsn_written_q),
    .vrf_req_o      (vrf_req_o),
    .vrf_addr_o     (vrf_addr_o),
    .vrf_wen_o      (vrf_wen_o),
    .vrf_wdata_o    (vrf_wdata_o),
    .vrf_be_o       (vrf_be_o),
    .vrf_tgt_o      (vrf_tgt_o)
  );

endmodule

// ==== operand_requester_checker.sv ====
/*
 * Concurrent assertions on the operand requester, bound to the top level.
 * Covers bank exclusivity, queue back-pressure and final grant timing.
 */
`timescale 1ns/1ns

module operand_requester_checker #(
  parameter  int unsigned NrBanks = 4,
  localparam int unsigned BankW   = $clog2(NrBanks)
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic [1:0]                   rd_gnt_i,
  input logic [1:0][BankW-1:0]        rd_bank_i,
  input logic                         alu_gnt_i,
  input opreq_pkg::vaddr_t            alu_addr_i,
  input logic                         ldu_gnt_i,
  input opreq_pkg::vaddr_t            ldu_addr_i,
  input logic [1:0]                   issued_i,
  input logic [1:0]                   queue_ready_i,
  input logic                         final_gnt_i
);
  // Grants landing on each bank in the current cycle
  logic [NrBanks-1:0][2:0] grants;

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      grants[b] = 3'd0;
      if (alu_gnt_i && (alu_addr_i[BankW-1:0] == BankW'(b))) grants[b] = grants[b] + 3'd1;
      if (ldu_gnt_i && (ldu_addr_i[BankW-1:0] == BankW'(b))) grants[b] = grants[b] + 3'd1;
      for (int q = 0; q < 2; q++) begin
        if (rd_gnt_i[q] && (rd_bank_i[q] == BankW'(b))) grants[b] = grants[b] + 3'd1;
      end
    end
  end

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    assert property (@(posedge clk_i) disable iff (!rst_ni) grants[b] <= 3'd1)
      else $error("bank %0d granted to more than one source", b);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issued_i & ~queue_ready_i) == 2'b00)
    else $error("operand issued while its queue was not ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    final_gnt_i == $past(ldu_gnt_i))
    else $error("load final grant does not follow the load write grant");

endmodule

bind operand_requester operand_requester_checker #(.NrBanks(NrBanks)) i_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .rd_gnt_i     (rd_gnt),
  .rd_bank_i    (rd_bank),
  .alu_gnt_i    (alu_result_gnt_o),
  .alu_addr_i   (alu_result_addr_i),
  .ldu_gnt_i    (ldu_wr_gnt),
  .ldu_addr_i   (ldu_addr),
  .issued_i     (operand_issued_o),
  .queue_ready_i(operand_queue_ready_i),
  .final_gnt_i  (ldu_result_final_gnt_o)
);

// ==== tb_operand_requester.sv ====
/*
 * Testbench for the lane operand requester.
 * Plays back the trace file test by test, watches every VRF bank access
 * and checks read order, write contents, load ordering and hazard pacing.
 */
`timescale 1ns/1ns

module tb_operand_requester;
  import opreq_pkg::*;

  localparam int NrBanks = 4;

  typedef struct {
    int          kind;  // 0 cmd, 1 alu, 2 ldu, 3 gap
    int          tst;
    int          q;
    int          id;
    int          vs;
    int          len;
    int          cyc;
    logic [7:0]  haz;
    logic [8:0]  addr;
    logic [63:0] data;
    logic [7:0]  be;
  } rec_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic [1:0]           valid;
  vid_t [1:0]           op_id;
  vreg_t [1:0]          op_vs;
  wlen_t [1:0]          op_len;
  logic [1:0][7:0]      op_haz;
  logic [1:0]           ready;
  logic [1:0]           queue_ready;
  logic [1:0]           issued;
  logic                 alu_req, alu_gnt, ldu_req, ldu_gnt, ldu_fin;
  vid_t                 alu_id, ldu_id;
  vaddr_t               alu_addr, ldu_addr;
  elen_t                alu_data, ldu_data;
  strb_t                alu_be, ldu_be;
  logic [3:0]           vrf_req, vrf_wen;
  logic [3:0][6:0]      vrf_addr;
  elen_t [3:0]          vrf_wdata;
  strb_t [3:0]          vrf_be;
  logic [3:0][0:0]      vrf_tgt;

  rec_t        recs[$];
  int          errors = 0;
  int          failed_tests = 0;
  int          ntests = 0;
  int          cycles = 0;
  int          limit = 200;
  logic [15:0] lfsr_q = 16'd33671;
  bit          trace_ok;

  always #20 clk_i = ~clk_i;

  operand_requester #(.NrBanks(NrBanks)) i_dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .operand_request_valid_i(valid),
    .op_id_i                (op_id),
    .op_vs_i                (op_vs),
    .op_len_i               (op_len),
    .op_hazard_i            (op_haz),
    .operand_request_ready_o(ready),
    .operand_queue_ready_i  (queue_ready),
    .operand_issued_o       (issued),
    .alu_result_req_i       (alu_req),
    .alu_result_id_i        (alu_id),
    .alu_result_addr_i      (alu_addr),
    .alu_result_wdata_i     (alu_data),
    .alu_result_be_i        (alu_be),
    .alu_result_gnt_o       (alu_gnt),
    .ldu_result_req_i       (ldu_req),
    .ldu_result_id_i        (ldu_id),
    .ldu_result_addr_i      (ldu_addr),
    .ldu_result_wdata_i     (ldu_data),
    .ldu_result_be_i        (ldu_be),
    .ldu_result_gnt_o       (ldu_gnt),
    .ldu_result_final_gnt_o (ldu_fin),
    .vrf_req_o              (vrf_req),
    .vrf_addr_o             (vrf_addr),
    .vrf_wen_o              (vrf_wen),
    .vrf_wdata_o            (vrf_wdata),
    .vrf_be_o               (vrf_be),
    .vrf_tgt_o              (vrf_tgt)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 16'hB400;
    return out;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic complain(input string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic read_trace(output bit ok);
    int          fd, n, v0, v1, v2, v3;
    logic [7:0]  h8, b8;
    logic [8:0]  a9;
    logic [63:0] d64;
    logic [127:0] kw;
    logic [1023:0] rest;
    rec_t        r;
    int          cur, sum;

    cur = 0;
    sum = 0;
    ok  = 1'b0;
    fd  = $fopen("opreq_trace.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fscanf(fd, "%s", kw) == 1) begin
        r = '{default: 0};
        r.tst = cur;
        if (kw == "#") begin
          n = $fgets(rest, fd);
        end else if (kw == "test") begin
          n = $fscanf(fd, "%d", cur);
          if (cur > ntests) ntests = cur;
        end else if (kw == "cmd") begin
          n = $fscanf(fd, "%d %d %d %d %h", v0, v1, v2, v3, h8);
          r.kind = 0;
          r.q    = v0;
          r.id   = v1;
          r.vs   = v2;
          r.len  = v3;
          r.haz  = h8;
          sum += v3;
          recs.push_back(r);
        end else if (kw == "alu" || kw == "ldu") begin
          n = $fscanf(fd, "%d %d %h %h %h", v0, v1, a9, d64, b8);
          r.kind = (kw == "alu") ? 1 : 2;
          r.cyc  = v0;
          r.id   = v1;
          r.addr = a9;
          r.data = d64;
          r.be   = b8;
          sum++;
          recs.push_back(r);
        end else if (kw == "fill") begin
          n = $fscanf(fd, "%d %d %h", v0, v1, a9);
          r.kind = 1;
          r.cyc  = v0;
          r.id   = v1;
          r.addr = a9;
          r.be   = 8'hff;
          for (int i = 0; i < 64; i++) r.data[i] = lfsr_bit();
          sum++;
          recs.push_back(r);
        end else if (kw == "gap") begin
          n = $fscanf(fd, "%d %d", v0, v1);
          r.kind = 3;
          r.q    = v0;
          r.len  = v1;
          recs.push_back(r);
        end
      end
      $fclose(fd);
      limit = 4 * sum + 200;
    end
  endtask

  task automatic run_test(input int t);
    int          cmd_q[2][$];
    int          exp_addr[2][$];
    int          exp_ser[2][$];
    logic [7:0]  exp_haz[2][$];
    int          alu_at[int];
    int          ldu_pend[$];
    int          ldu_exp[$];
    int          gap[2], cur_ser[2], rd_cnt[2], rd_now[2], wr_cnt[8];
    int          cyc, last_cyc, tail, nld, fin, err0, ser, a, q, s;
    logic        alu_on, seen;
    logic [7:0]  hz;
    rec_t        r;

    err0     = errors;
    cyc      = 0;
    last_cyc = 0;
    tail     = 0;
    nld      = 0;
    fin      = 0;
    ser      = 0;
    gap      = '{0, 0};
    cur_ser  = '{-1, -1};
    rd_cnt   = '{0, 0};
    wr_cnt   = '{default: 0};
    foreach (recs[i]) begin
      if (recs[i].tst == t) begin
        case (recs[i].kind)
          0: cmd_q[recs[i].q].push_back(i);
          1: alu_at[recs[i].cyc] = i;
          2: begin
            ldu_pend.push_back(i);
            nld++;
          end
          default: gap[recs[i].q] = recs[i].len;
        endcase
        if (recs[i].kind == 1 || recs[i].kind == 2) begin
          if (recs[i].cyc > last_cyc) last_cyc = recs[i].cyc;
        end
      end
    end

    while (tail < 3) begin
      @(negedge clk_i);
      for (int k = 0; k < 2; k++) begin
        valid[k] = (cmd_q[k].size() > 0);
        if (valid[k]) begin
          r = recs[cmd_q[k][0]];
          op_id[k]  = vid_t'(r.id);
          op_vs[k]  = vreg_t'(r.vs);
          op_len[k] = wlen_t'(r.len);
          op_haz[k] = r.haz;
        end
        queue_ready[k] = (cyc < gap[k]) ? lfsr_bit() : 1'b1;
      end
      alu_on  = alu_at.exists(cyc);
      alu_req = alu_on;
      if (alu_on) begin
        r = recs[alu_at[cyc]];
        alu_id   = vid_t'(r.id);
        alu_addr = r.addr;
        alu_data = r.data;
        alu_be   = r.be;
      end
      ldu_req = (ldu_pend.size() > 0) && (recs[ldu_pend[0]].cyc <= cyc);
      if (ldu_req) begin
        r = recs[ldu_pend[0]];
        ldu_id   = vid_t'(r.id);
        ldu_addr = r.addr;
        ldu_data = r.data;
        ldu_be   = r.be;
      end
      #19;

      // Load acceptance while the buffer has a free slot
      check_value("ldu_result_gnt_o", 64'(ldu_gnt), 64'(ldu_exp.size() < 2));
      if (ldu_req && ldu_gnt) ldu_exp.push_back(ldu_pend.pop_front());
      fin += int'(ldu_fin);

      // Writes first, so the hazard counts include this cycle
      seen = 1'b0;
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req[b] && vrf_wen[b]) begin
          $display("  cycle %0d bank %0d write row %h", cyc, b, vrf_addr[b]);
          if (alu_on && !seen && (int'(alu_addr) % NrBanks == b)) begin
            r = recs[alu_at[cyc]];
            seen = 1'b1;
          end else if (ldu_exp.size() > 0) begin
            r = recs[ldu_exp.pop_front()];
            check_value("load write bank", 64'(b), 64'(int'(r.addr) % NrBanks));
          end else begin
            complain($sformatf("unexpected write at bank %0d", b));
            continue;
          end
          check_value("vrf_addr_o", 64'(vrf_addr[b]), 64'(int'(r.addr) / NrBanks));
          check_value("vrf_wdata_o", vrf_wdata[b], r.data);
          check_value("vrf_be_o", 64'(vrf_be[b]), 64'(r.be));
          wr_cnt[r.id]++;
        end
      end
      if (alu_on) begin
        check_value("alu_result_gnt_o", 64'(alu_gnt), 64'd1);
        if (!seen) complain("arithmetic write did not reach its bank");
      end

      // Reads in the order each queue issued them
      rd_now = '{0, 0};
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req[b] && !vrf_wen[b]) begin
          q = int'(vrf_tgt[b]);
          rd_now[q]++;
          $display("  cycle %0d bank %0d read row %h queue %0d", cyc, b, vrf_addr[b], q);
          if (exp_addr[q].size() == 0) begin
            complain($sformatf("queue %0d read more words than commanded", q));
            continue;
          end
          a  = exp_addr[q].pop_front();
          s  = exp_ser[q].pop_front();
          hz = exp_haz[q].pop_front();
          check_value("read bank", 64'(b), 64'(a % NrBanks));
          check_value("vrf_addr_o", 64'(vrf_addr[b]), 64'(a / NrBanks));
          if (s != cur_ser[q]) begin
            cur_ser[q] = s;
            rd_cnt[q]  = 0;
          end
          rd_cnt[q]++;
          for (int h = 0; h < 8; h++) begin
            if (hz[h] && rd_cnt[q] > wr_cnt[h])
              complain($sformatf("queue %0d read ahead of the writes of id %0d", q, h));
          end
        end
      end

      // A command is taken when idle or on the last word of the one before
      for (int k = 0; k < 2; k++) begin
        check_value($sformatf("operand_request_ready_o[%0d]", k), 64'(ready[k]),
                    64'(valid[k] && (exp_addr[k].size() == 0)));
        if (valid[k] && ready[k]) begin
          r = recs[cmd_q[k].pop_front()];
          for (int w = 0; w < r.len; w++) begin
            exp_addr[k].push_back(r.vs * 16 + w);
            exp_ser[k].push_back(ser);
            exp_haz[k].push_back(r.haz);
          end
          ser++;
        end
      end
      for (int k = 0; k < 2; k++) begin
        check_value($sformatf("operand_issued_o[%0d]", k), 64'(issued[k]), 64'(rd_now[k]));
        if (!queue_ready[k] && rd_now[k] > 0)
          complain($sformatf("queue %0d read while its queue was not ready", k));
      end

      cyc++;
      if (cmd_q[0].size() == 0 && cmd_q[1].size() == 0 && exp_addr[0].size() == 0 &&
          exp_addr[1].size() == 0 && ldu_pend.size() == 0 && ldu_exp.size() == 0 &&
          cyc > last_cyc) begin
        tail++;
      end
    end
    check_value("ldu_result_final_gnt_o pulses", 64'(fin), 64'(nld));
    if (errors != err0) failed_tests++;
    $display("test %0d: %s (%0d errors)", t, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  // Cycle counter that ends a run which stops making progress
  initial begin
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    valid       = '0;
    op_id       = '0;
    op_vs       = '0;
    op_len      = '0;
    op_haz      = '0;
    queue_ready = '1;
    alu_req     = 1'b0;
    alu_id      = '0;
    alu_addr    = '0;
    alu_data    = '0;
    alu_be      = '0;
    ldu_req     = 1'b0;
    ldu_id      = '0;
    ldu_addr    = '0;
    ldu_data    = '0;
    ldu_be      = '0;
    read_trace(trace_ok);
    if (!trace_ok) begin
      $display("Error: cannot open the trace file");
      $display("=== FAIL ===");
      $finish;
    end else begin
      repeat (5) @(negedge clk_i);
      rst_ni = 1'b1;
      for (int t = 1; t <= ntests; t++) run_test(t);
      $display("tests run: %0d, failed: %0d, errors: %0d", ntests, failed_tests, errors);
      if (errors == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

// ==== opreq_trace.txt ====
# Keywords: test n ... end; cmd q id vs len hazard_hex; gap q cycles (random queue ready)
# alu/ldu cycle id addr_hex data_hex be_hex; fill cycle id addr_hex (random data, all bytes)
test 1
cmd 0 0 3 5 00
cmd 1 1 7 6 00
end
test 2
cmd 0 2 1 0 00
cmd 0 2 4 3 00
cmd 1 3 9 2 00
end
test 3
cmd 0 0 0 8 00
cmd 1 1 1 8 00
alu 2 3 100 0123456789abcdef ff
alu 3 3 101 fedcba9876543210 0f
fill 4 3 102
fill 5 3 103
end
test 4
ldu 1 4 040 1111111111111111 ff
ldu 1 4 041 2222222222222222 f0
ldu 1 4 042 3333333333333333 ff
alu 2 6 080 aaaaaaaaaaaaaaaa ff
alu 3 6 084 bbbbbbbbbbbbbbbb ff
alu 4 6 085 cccccccccccccccc 3c
end
test 5
cmd 0 1 2 3 20
alu 3 5 1f0 0000000000000005 ff
alu 6 5 1f1 0000000000000006 ff
alu 9 5 1f2 0000000000000007 ff
end
test 6
gap 0 20
gap 1 20
cmd 0 0 5 10 00
cmd 1 1 6 10 00
end

// ==== sim.f ====
opreq_pkg.sv
result_spill_reg.sv
operand_req_fsm.sv
vrf_bank_arbiter.sv
operand_requester.sv
operand_requester_checker.sv
tb_operand_requester.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_operand_requester -o Vtb
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

out=$(./obj_dir/Vtb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
